//--- include/jbi_mondo_config.svh
//**************************************************************************
// JBus mondo path sizes
// Depth of the mondo ack queue, ID field widths and the minimum
// spacing of JBus replies
//**************************************************************************

`ifndef JBI_MONDO_CONFIG_SVH
`define JBI_MONDO_CONFIG_SVH

// Mondo ack queue slots
`define JBI_MAKQ_DEPTH 8

// Slot index, pointers add one wrap bit on top
`define JBI_MAKQ_ADDR_WIDTH 3

// JBus interrupt ID fields
`define JBI_AD_INT_AGTID_WIDTH 5
`define JBI_AD_INT_CPUID_WIDTH 6

// Idle cycles required between two JBus replies
`define JBI_MONDO_REPLY_GAP 3

// Gap counter width, must hold JBI_MONDO_REPLY_GAP
`define JBI_MONDO_GAP_WIDTH 2

`endif

//--- design/jbi_mondo_pkg.sv
//**************************************************************************
// JBus mondo path types
// Word layouts shared by the receive, queue and reply blocks
//**************************************************************************

`include "jbi_mondo_config.svh"

package jbi_mondo_pkg;

   // One ID queue word, 11 bits
   typedef struct packed {
      logic [`JBI_AD_INT_AGTID_WIDTH-1:0] agnt_id;
      logic [`JBI_AD_INT_CPUID_WIDTH-1:0] cpu_id;
   } makq_entry_t;

   // Interrupt word as it arrives from JBus
   // Parity makes all 12 bits odd
   typedef struct packed {
      logic [`JBI_AD_INT_AGTID_WIDTH-1:0] agnt_id;
      logic [`JBI_AD_INT_CPUID_WIDTH-1:0] cpu_id;
      logic                               parity;
   } mondo_in_t;

   // Reply word back to JBus
   typedef struct packed {
      logic                               ack;     // 1 = ack, 0 = nack
      logic [`JBI_AD_INT_AGTID_WIDTH-1:0] agnt_id;
      logic [`JBI_AD_INT_CPUID_WIDTH-1:0] cpu_id;
   } mondo_reply_t;

endpackage

//--- design/jbi_ncio_makq_ram.sv
//**************************************************************************
// Mondo ID queue storage
// Register file, clocked write and combinational read
//**************************************************************************

`include "jbi_mondo_config.svh"

module jbi_ncio_makq_ram
   import jbi_mondo_pkg::*;
(
   input  logic                            clk,
   input  logic                            makq_wr_en,
   input  logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_waddr,
   input  logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_raddr,
   input  makq_entry_t                     makq_wdata,
   output makq_entry_t                     makq_rdata
);

   makq_entry_t mem [`JBI_MAKQ_DEPTH];

   // Write at end of push cycle
   always_ff @(posedge clk) begin
      if (makq_wr_en) begin
         mem[makq_waddr] <= makq_wdata;
      end
   end

   // Read data meaningful only while the queue holds an acked slot
   assign makq_rdata = mem[makq_raddr];

endmodule

//--- design/jbi_ncio_makq_ctl.sv
//**************************************************************************
// Mondo ack queue control
// ID, ack and read pointers of the mondo ack queue, one ack bit per
// slot, and the fill level of acked but unreplied mondos
//**************************************************************************

`include "jbi_mondo_config.svh"

module jbi_ncio_makq_ctl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            makq_push,
   input  logic                            makq_nack,
   input  logic                            iob_mondo_ack,
   input  logic                            iob_mondo_nack,
   input  logic                            mondo_pop,
   output logic                            makq_wr_en,
   output logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_waddr,
   output logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_raddr,
   output logic                            mondo_req,
   output logic                            mondo_ack,
   output logic [`JBI_MAKQ_ADDR_WIDTH:0]   makq_level
);

   // Pointers carry a wrap bit above the slot index
   logic [`JBI_MAKQ_ADDR_WIDTH:0] id_wptr;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] ack_wptr;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] rptr;
   logic [`JBI_MAKQ_DEPTH-1:0]    ack;

   logic [`JBI_MAKQ_ADDR_WIDTH:0] next_id_wptr;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] next_ack_wptr;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] next_rptr;
   logic [`JBI_MAKQ_DEPTH-1:0]    next_ack;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] next_level;

   logic bad_push;
   logic ack_push;
   logic makq_empty;
   logic makq_full;

   //**************************************************************************
   // Push
   //**************************************************************************

   // ID slot taken by every incoming word
   assign next_id_wptr = makq_push ? id_wptr + 1'b1 : id_wptr;
   assign makq_wr_en   = makq_push;
   assign makq_waddr   = id_wptr[`JBI_MAKQ_ADDR_WIDTH-1:0];

   // Parity error word is nacked here instead of by the IOB
   assign bad_push = makq_push & makq_nack;
   assign ack_push = iob_mondo_ack | iob_mondo_nack | bad_push;

   always_comb begin
      next_ack = ack;
      if (ack_push) begin
         next_ack[ack_wptr[`JBI_MAKQ_ADDR_WIDTH-1:0]] = iob_mondo_ack & ~bad_push;
      end
   end

   assign next_ack_wptr = ack_push ? ack_wptr + 1'b1 : ack_wptr;

   //**************************************************************************
   // Pop
   //**************************************************************************

   assign next_rptr = mondo_pop ? rptr + 1'b1 : rptr;

   // Only slots with a recorded ack bit are visible to the reply side
   assign makq_empty = rptr == ack_wptr;
   assign makq_raddr = rptr[`JBI_MAKQ_ADDR_WIDTH-1:0];
   assign mondo_req  = ~makq_empty;
   assign mondo_ack  = ack[rptr[`JBI_MAKQ_ADDR_WIDTH-1:0]];

   // Up/down count, simultaneous write and pop cancel
   always_comb begin
      case ({ack_push, mondo_pop})
         2'b10:   next_level = makq_level + 1'b1;
         2'b01:   next_level = makq_level - 1'b1;
         default: next_level = makq_level;
      endcase
   end

   //**************************************************************************
   // State
   //**************************************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_wptr    <= '0;
         ack_wptr   <= '0;
         rptr       <= '0;
         ack        <= '0;
         makq_level <= '0;
      end else begin
         id_wptr    <= next_id_wptr;
         ack_wptr   <= next_ack_wptr;
         rptr       <= next_rptr;
         ack        <= next_ack;
         makq_level <= next_level;
      end
   end

   //**************************************************************************
   // Checks
   //**************************************************************************

   // Every ID slot in use, replied or not
   assign makq_full =
      (id_wptr[`JBI_MAKQ_ADDR_WIDTH] != rptr[`JBI_MAKQ_ADDR_WIDTH]) &&
      (id_wptr[`JBI_MAKQ_ADDR_WIDTH-1:0] == rptr[`JBI_MAKQ_ADDR_WIDTH-1:0]);

   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      makq_push |-> !makq_full)
      else $error("jbi_ncio_makq_ctl: MAKQ overflow");

   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      mondo_pop |-> !makq_empty)
      else $error("jbi_ncio_makq_ctl: MAKQ underflow");

   a_iob_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      !(iob_mondo_ack && iob_mondo_nack))
      else $error("jbi_ncio_makq_ctl: IOB ack and nack together");

   // Keeps ack slots lined up with ID slots
   a_bad_push_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      bad_push |-> ack_wptr == id_wptr)
      else $error("jbi_ncio_makq_ctl: bad parity push with IOB mondo pending");

   a_bad_push_alone : assert property (@(posedge clk) disable iff (!rst_n)
      bad_push |-> !(iob_mondo_ack || iob_mondo_nack))
      else $error("jbi_ncio_makq_ctl: IOB response during bad parity push");

endmodule

//--- design/jbi_mondo_rx.sv
//**************************************************************************
// JBus mondo receive
// Registers interrupt words, checks odd parity, pushes every word into
// the ID queue and forwards only good words to the IOB
//**************************************************************************

module jbi_mondo_rx
   import jbi_mondo_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        mondo_in_valid,
   input  mondo_in_t   mondo_in,
   output logic        makq_push,
   output logic        makq_nack,
   output logic        iob_mondo_req,
   output makq_entry_t makq_wdata,
   output makq_entry_t iob_mondo_entry
);

   logic      mondo_valid_q;
   mondo_in_t mondo_q;
   logic      par_ok;

   // Input strobe flop
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mondo_valid_q <= 1'b0;
      end else begin
         mondo_valid_q <= mondo_in_valid;
      end
   end

   // Word flop loaded only with a strobe
   always_ff @(posedge clk) begin
      if (mondo_in_valid) begin
         mondo_q <= mondo_in;
      end
   end

   // Odd parity over all 12 bits
   assign par_ok = ^mondo_q;

   // Every word takes a queue slot
   assign makq_push = mondo_valid_q;
   // Bad parity gets nacked on JBus and never reaches the IOB
   assign makq_nack = mondo_valid_q & ~par_ok;
   assign iob_mondo_req = mondo_valid_q & par_ok;

   assign makq_wdata.agnt_id = mondo_q.agnt_id;
   assign makq_wdata.cpu_id  = mondo_q.cpu_id;
   assign iob_mondo_entry    = makq_wdata;

   // Each pushed word is classified as good or bad
   a_push_classified : assert property (@(posedge clk) disable iff (!rst_n)
      makq_push |-> !$isunknown({makq_nack, iob_mondo_req}))
      else $error("jbi_mondo_rx: push with unknown parity result");

endmodule

//--- design/jbi_mondo_reply.sv
//**************************************************************************
// JBus mondo reply
// Pops the ack queue in order and issues one ack or nack reply per
// mondo, keeping a minimum gap between replies
//**************************************************************************

`include "jbi_mondo_config.svh"

module jbi_mondo_reply
   import jbi_mondo_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         mondo_req,
   input  logic         mondo_ack,
   input  makq_entry_t  makq_rdata,
   output logic         mondo_pop,
   output logic         reply_valid,
   output mondo_reply_t reply
);

   logic [`JBI_MONDO_GAP_WIDTH-1:0] gap_cnt;

   // Pop as soon as the spacing allows
   assign mondo_pop = mondo_req & (gap_cnt == '0);

   //**************************************************************************
   // Reply spacing
   //**************************************************************************

   // Loaded on pop, so the next pop is GAP+1 cycles later at the earliest
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gap_cnt <= '0;
      end else if (mondo_pop) begin
         gap_cnt <= `JBI_MONDO_GAP_WIDTH'(`JBI_MONDO_REPLY_GAP);
      end else if (gap_cnt != '0) begin
         gap_cnt <= gap_cnt - 1'b1;
      end
   end

   //**************************************************************************
   // Reply word
   //**************************************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reply_valid <= 1'b0;
      end else begin
         reply_valid <= mondo_pop;
      end
   end

   // Captured from the head slot in the pop cycle
   always_ff @(posedge clk) begin
      if (mondo_pop) begin
         reply.ack     <= mondo_ack;
         reply.agnt_id <= makq_rdata.agnt_id;
         reply.cpu_id  <= makq_rdata.cpu_id;
      end
   end

   // Replies on JBus never closer than the required gap
   a_reply_gap : assert property (@(posedge clk) disable iff (!rst_n)
      mondo_pop |=> !mondo_pop [* `JBI_MONDO_REPLY_GAP])
      else $error("jbi_mondo_reply: reply gap violated");

endmodule

//--- design/jbi_mondo_top.sv
//**************************************************************************
// JBus mondo path
// Receive, ack queue control and storage, and reply blocks
//**************************************************************************

`include "jbi_mondo_config.svh"

module jbi_mondo_top
   import jbi_mondo_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          mondo_in_valid,
   input  mondo_in_t                     mondo_in,
   input  logic                          iob_mondo_ack,
   input  logic                          iob_mondo_nack,
   output logic                          iob_mondo_req,
   output makq_entry_t                   iob_mondo_entry,
   output logic                          reply_valid,
   output mondo_reply_t                  reply,
   output logic [`JBI_MAKQ_ADDR_WIDTH:0] makq_level
);

   // Receive to queue
   logic        makq_push;
   logic        makq_nack;
   makq_entry_t makq_wdata;

   // Queue control to storage
   logic                            makq_wr_en;
   logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_waddr;
   logic [`JBI_MAKQ_ADDR_WIDTH-1:0] makq_raddr;
   makq_entry_t                     makq_rdata;

   // Queue to reply
   logic mondo_req;
   logic mondo_ack;
   logic mondo_pop;

   jbi_mondo_rx rx_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .mondo_in_valid  (mondo_in_valid),
      .mondo_in        (mondo_in),
      .makq_push       (makq_push),
      .makq_nack       (makq_nack),
      .iob_mondo_req   (iob_mondo_req),
      .makq_wdata      (makq_wdata),
      .iob_mondo_entry (iob_mondo_entry)
   );

   jbi_ncio_makq_ctl makq_ctl_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .makq_push      (makq_push),
      .makq_nack      (makq_nack),
      .iob_mondo_ack  (iob_mondo_ack),
      .iob_mondo_nack (iob_mondo_nack),
      .mondo_pop      (mondo_pop),
      .makq_wr_en     (makq_wr_en),
      .makq_waddr     (makq_waddr),
      .makq_raddr     (makq_raddr),
      .mondo_req      (mondo_req),
      .mondo_ack      (mondo_ack),
      .makq_level     (makq_level)
   );

   jbi_ncio_makq_ram makq_ram_i (
      .clk        (clk),
      .makq_wr_en (makq_wr_en),
      .makq_waddr (makq_waddr),
      .makq_raddr (makq_raddr),
      .makq_wdata (makq_wdata),
      .makq_rdata (makq_rdata)
   );

   jbi_mondo_reply reply_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .mondo_req   (mondo_req),
      .mondo_ack   (mondo_ack),
      .makq_rdata  (makq_rdata),
      .mondo_pop   (mondo_pop),
      .reply_valid (reply_valid),
      .reply       (reply)
   );

endmodule

//--- test/tb_jbi_mondo.sv
//**************************************************************************
// Mondo path testbench
// Applies a table of interrupt words, models the IOB answers and
// checks requests, replies, reply spacing and the queue level
//**************************************************************************

`include "jbi_mondo_config.svh"

module tb_jbi_mondo
   import jbi_mondo_pkg::*;
#(
   parameter int unsigned seed = 32'hdff9
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_rows    = 16;
   localparam int run_limit   = 2000;
   localparam int drain_limit = 50;

   // One stimulus row
   typedef struct packed {
      logic [`JBI_AD_INT_AGTID_WIDTH-1:0] agnt_id;
      logic [`JBI_AD_INT_CPUID_WIDTH-1:0] cpu_id;
      logic                               bad_par;
      logic                               iob_ack;   // IOB answer for a good word
      logic [3:0]                         delay;
   } stim_row_t;

   // IOB answer waiting for its cycle
   typedef struct packed {
      logic        iob_ack;
      logic [31:0] due;
   } iob_resp_t;

   logic                          clk;
   logic                          rst_n;
   logic                          mondo_in_valid;
   mondo_in_t                     mondo_in;
   logic                          iob_mondo_ack;
   logic                          iob_mondo_nack;
   logic                          iob_mondo_req;
   makq_entry_t                   iob_mondo_entry;
   logic                          reply_valid;
   mondo_reply_t                  reply;
   logic [`JBI_MAKQ_ADDR_WIDTH:0] makq_level;

   stim_row_t    stim [num_rows];
   stim_row_t    req_q [$];     // good words still owed an IOB request
   mondo_reply_t reply_q [$];   // expected replies in send order
   iob_resp_t    iob_q [$];

   int unsigned cyc;
   int unsigned last_due;
   int unsigned last_reply_cyc;
   logic        seen_reply;
   int          next_row;
   int          sent;
   int          replies;
   int          iob_pending;    // good words with no IOB answer driven yet
   int          acks_written;   // IOB answers driven plus bad words sent
   int          max_level;
   int          value_errors;
   int          other_errors;

   jbi_mondo_top dut_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .mondo_in_valid  (mondo_in_valid),
      .mondo_in        (mondo_in),
      .iob_mondo_ack   (iob_mondo_ack),
      .iob_mondo_nack  (iob_mondo_nack),
      .iob_mondo_req   (iob_mondo_req),
      .iob_mondo_entry (iob_mondo_entry),
      .reply_valid     (reply_valid),
      .reply           (reply),
      .makq_level      (makq_level)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //**************************************************************************
   // Stimulus table
   //**************************************************************************

   task automatic load_table();
      // Burst of acks, late first answer packs the rest back to back
      stim[0]  = '{5'h01, 6'h10, 1'b0, 1'b1, 4'd6};
      stim[1]  = '{5'h02, 6'h11, 1'b0, 1'b1, 4'd0};
      stim[2]  = '{5'h03, 6'h12, 1'b0, 1'b1, 4'd0};
      stim[3]  = '{5'h04, 6'h13, 1'b0, 1'b1, 4'd0};
      stim[4]  = '{5'h05, 6'h14, 1'b0, 1'b0, 4'd2};
      stim[5]  = '{5'h06, 6'h15, 1'b1, 1'b1, 4'd0};
      // Enough words to fill the queue
      stim[6]  = '{5'h07, 6'h20, 1'b0, 1'b1, 4'd0};
      stim[7]  = '{5'h08, 6'h21, 1'b0, 1'b0, 4'd1};
      stim[8]  = '{5'h09, 6'h22, 1'b0, 1'b1, 4'd0};
      stim[9]  = '{5'h0a, 6'h23, 1'b0, 1'b1, 4'd0};
      stim[10] = '{5'h0b, 6'h24, 1'b0, 1'b0, 4'd3};
      stim[11] = '{5'h0c, 6'h25, 1'b0, 1'b1, 4'd0};
      stim[12] = '{5'h0d, 6'h26, 1'b0, 1'b1, 4'd0};
      stim[13] = '{5'h0e, 6'h27, 1'b1, 1'b0, 4'd0};
      stim[14] = '{5'h1f, 6'h3f, 1'b0, 1'b0, 4'd5};
      stim[15] = '{5'h10, 6'h00, 1'b1, 1'b1, 4'd0};
   endtask

   //**************************************************************************
   // Monitor and scoreboard, sampled mid cycle
   //**************************************************************************

   task automatic check_outputs();
      stim_row_t    exp_req;
      mondo_reply_t exp_reply;
      iob_resp_t    resp;
      if (iob_mondo_req) begin
         if (req_q.size() == 0) begin
            other_errors++;
            $display("IOB request at %0t with no good word outstanding", $time);
         end else begin
            exp_req = req_q.pop_front();
            if (iob_mondo_entry.agnt_id !== exp_req.agnt_id ||
                iob_mondo_entry.cpu_id !== exp_req.cpu_id) begin
               value_errors++;
               $display("FAILED @%0t: IOB request IDs %0h/%0h, expected %0h/%0h", $time,
                        iob_mondo_entry.agnt_id, iob_mondo_entry.cpu_id,
                        exp_req.agnt_id, exp_req.cpu_id);
            end
            // IOB answers in request order, one per cycle at most
            resp.iob_ack = exp_req.iob_ack;
            resp.due     = cyc + 1 + exp_req.delay;
            if (resp.due <= last_due) begin
               resp.due = last_due + 1;
            end
            last_due = resp.due;
            iob_q.push_back(resp);
         end
      end
      if (reply_valid) begin
         replies++;
         if (seen_reply && (cyc - last_reply_cyc < `JBI_MONDO_REPLY_GAP + 1)) begin
            value_errors++;
            $display("FAILED @%0t: replies %0d cycles apart", $time, cyc - last_reply_cyc);
         end
         seen_reply     = 1'b1;
         last_reply_cyc = cyc;
         if (reply_q.size() == 0) begin
            other_errors++;
            $display("Reply at %0t with no word outstanding", $time);
         end else begin
            exp_reply = reply_q.pop_front();
            if (reply !== exp_reply) begin
               value_errors++;
               $display("FAILED @%0t: reply ack %0b IDs %0h/%0h, expected %0b %0h/%0h",
                        $time, reply.ack, reply.agnt_id, reply.cpu_id,
                        exp_reply.ack, exp_reply.agnt_id, exp_reply.cpu_id);
            end
         end
      end
      // Level bounded by acked slots not yet replied
      if (int'(makq_level) > acks_written - replies) begin
         value_errors++;
         $display("FAILED @%0t: makq_level %0d above %0d acked unreplied", $time,
                  makq_level, acks_written - replies);
      end
      if (int'(makq_level) > max_level) begin
         max_level = int'(makq_level);
      end
   endtask

   //**************************************************************************
   // IOB model and word driver, both on the falling edge
   //**************************************************************************

   task automatic drive_iob();
      iob_resp_t resp;
      iob_mondo_ack  = 1'b0;
      iob_mondo_nack = 1'b0;
      if (iob_q.size() != 0 && iob_q[0].due <= cyc) begin
         resp           = iob_q.pop_front();
         iob_mondo_ack  = resp.iob_ack;
         iob_mondo_nack = ~resp.iob_ack;
         iob_pending--;
         acks_written++;
      end
   endtask

   task automatic drive_word();
      stim_row_t    row;
      mondo_reply_t exp_reply;
      mondo_in_valid = 1'b0;
      if (next_row >= num_rows || sent - replies >= `JBI_MAKQ_DEPTH) begin
         return;
      end
      row = stim[next_row];
      // Bad word waits until every good word has its IOB answer
      if (row.bad_par && iob_pending != 0) begin
         return;
      end
      // Random idle cycles
      if ($urandom % 4 == 0) begin
         return;
      end
      mondo_in.agnt_id = row.agnt_id;
      mondo_in.cpu_id  = row.cpu_id;
      // Odd parity over all 12 bits, flipped for a corrupt word
      mondo_in.parity  = ~(^{row.agnt_id, row.cpu_id}) ^ row.bad_par;
      mondo_in_valid   = 1'b1;
      exp_reply.ack     = row.bad_par ? 1'b0 : row.iob_ack;
      exp_reply.agnt_id = row.agnt_id;
      exp_reply.cpu_id  = row.cpu_id;
      reply_q.push_back(exp_reply);
      if (row.bad_par) begin
         acks_written++;
      end else begin
         req_q.push_back(row);
         iob_pending++;
      end
      sent++;
      next_row++;
   endtask

   //**************************************************************************
   // Main sequence
   //**************************************************************************

   initial begin
      int wait_cyc;
      void'($urandom(seed));
      rst_n          = 1'b0;
      mondo_in_valid = 1'b0;
      mondo_in       = '0;
      iob_mondo_ack  = 1'b0;
      iob_mondo_nack = 1'b0;
      cyc            = 0;
      last_due       = 0;
      last_reply_cyc = 0;
      seen_reply     = 1'b0;
      next_row       = 0;
      sent           = 0;
      replies        = 0;
      iob_pending    = 0;
      acks_written   = 0;
      max_level      = 0;
      value_errors   = 0;
      other_errors   = 0;
      load_table();

      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      // Quiet outputs out of reset
      if (reply_valid !== 1'b0 || iob_mondo_req !== 1'b0 || makq_level !== '0) begin
         value_errors++;
         $display("FAILED @%0t: outputs not idle after reset", $time);
      end

      wait_cyc = 0;
      while (!(next_row == num_rows && replies == sent) && wait_cyc < run_limit) begin
         @(negedge clk);
         cyc++;
         wait_cyc++;
         check_outputs();
         drive_iob();
         drive_word();
      end
      mondo_in_valid = 1'b0;
      iob_mondo_ack  = 1'b0;
      iob_mondo_nack = 1'b0;
      if (!(next_row == num_rows && replies == sent)) begin
         other_errors++;
         $display("Timeout with %0d of %0d words sent and %0d replies", sent, num_rows,
                  replies);
      end

      // Watch for stray replies while the queue drains
      wait_cyc = 0;
      while (wait_cyc < drain_limit) begin
         @(negedge clk);
         cyc++;
         wait_cyc++;
         check_outputs();
      end
      if (replies != num_rows || req_q.size() != 0) begin
         value_errors++;
         $display("FAILED @%0t: %0d replies and %0d requests missing for %0d words", $time,
                  replies, req_q.size(), num_rows);
      end
      if (makq_level !== '0) begin
         value_errors++;
         $display("FAILED @%0t: makq_level %0d after last reply", $time, makq_level);
      end
      if (max_level < 2) begin
         value_errors++;
         $display("FAILED @%0t: makq_level peaked at %0d", $time, max_level);
      end

      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+include
design/jbi_mondo_pkg.sv
design/jbi_ncio_makq_ram.sv
design/jbi_ncio_makq_ctl.sv
design/jbi_mondo_rx.sv
design/jbi_mondo_reply.sv
design/jbi_mondo_top.sv
test/tb_jbi_mondo.sv

//--- Makefile
# Verilator lint, build and run for the JBus mondo path testbench

VERILATOR ?= verilator
TOP       ?= tb_jbi_mondo
SEED      ?= 57337
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -Gseed=$(SEED) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
